// File: logic/rob_pkg.sv
package rob_pkg;

  // datapath widths.
  localparam int word_width = 16;
  localparam int pc_width = 8;
  localparam int reg_width = 3;

  // reorder buffer sizing.
  localparam int rob_depth = 8;
  localparam int tag_width = $clog2(rob_depth);
  localparam int count_width = $clog2(rob_depth + 1);

  // free entries kept in reserve for instructions still on their way to allocation.
  localparam int full_margin = 3;

  // number of register stages in the multiplier.
  localparam int mul_latency = 3;

  typedef logic [word_width-1:0] word_t;
  typedef logic [pc_width-1:0] pc_t;
  typedef logic [reg_width-1:0] reg_t;
  typedef logic [tag_width-1:0] tag_t;
  typedef logic [count_width-1:0] count_t;

  typedef enum logic [1:0] {
    op_add,
    op_sub,
    op_mul,
    op_beq
  } op_e;

  typedef enum logic [1:0] {
    st_free,
    st_waiting,
    st_done
  } entry_state_e;

endpackage

// File: logic/issue_stage.sv
module issue_stage (
  input  logic             global_bus,
  input  logic             rst,
  input  logic             flush,
  input  logic             in_valid,
  input  rob_pkg::op_e     in_op,
  input  rob_pkg::pc_t     in_pc,
  input  rob_pkg::reg_t    in_rd,
  input  rob_pkg::word_t   in_a,
  input  rob_pkg::word_t   in_b,
  input  rob_pkg::pc_t     in_target,
  input  rob_pkg::tag_t    alloc_tag,
  output logic             alloc_valid,
  output rob_pkg::pc_t     alloc_pc,
  output rob_pkg::reg_t    alloc_rd,
  output logic             alu_valid,
  output logic             mul_valid,
  output rob_pkg::op_e     disp_op,
  output rob_pkg::word_t   disp_a,
  output rob_pkg::word_t   disp_b,
  output rob_pkg::pc_t     disp_target,
  output rob_pkg::tag_t    disp_tag
);

  logic           valid_q;
  rob_pkg::op_e   op_q;
  rob_pkg::pc_t   pc_q;
  rob_pkg::reg_t  rd_q;
  rob_pkg::word_t a_q;
  rob_pkg::word_t b_q;
  rob_pkg::pc_t   target_q;

  // an instruction sampled during a flush belongs to the squashed path.
  always_ff @(posedge global_bus) begin
    if (rst || flush) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge global_bus) begin
    if (in_valid) begin
      op_q     <= in_op;
      pc_q     <= in_pc;
      rd_q     <= (in_op == rob_pkg::op_beq) ? '0 : in_rd;
      a_q      <= in_a;
      b_q      <= in_b;
      target_q <= in_target;
    end
  end

  assign alloc_valid = valid_q;
  assign alloc_pc    = pc_q;
  assign alloc_rd    = rd_q;

  // route by opcode, only the multiply goes to the slow unit.
  assign alu_valid   = valid_q && (op_q != rob_pkg::op_mul);
  assign mul_valid   = valid_q && (op_q == rob_pkg::op_mul);

  assign disp_op     = op_q;
  assign disp_a      = a_q;
  assign disp_b      = b_q;
  assign disp_target = target_q;

  // tag is the tail the buffer allocates this cycle.
  assign disp_tag    = alloc_tag;

endmodule

// File: logic/alu_unit.sv
module alu_unit (
  input  logic            global_bus,
  input  logic            rst,
  input  logic            flush,
  input  logic            alu_valid,
  input  rob_pkg::op_e    disp_op,
  input  rob_pkg::word_t  disp_a,
  input  rob_pkg::word_t  disp_b,
  input  rob_pkg::tag_t   disp_tag,
  output logic            alu_wb_valid,
  output rob_pkg::tag_t   alu_wb_tag,
  output rob_pkg::word_t  alu_wb_value,
  output logic            alu_wb_taken
);

  rob_pkg::word_t result;
  logic           taken;

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (disp_op)
      rob_pkg::op_add: result = disp_a + disp_b;
      rob_pkg::op_sub: result = disp_a - disp_b;
      // branches write no register, so the value stays zero.
      rob_pkg::op_beq: taken = (disp_a == disp_b);
      default: result = '0;
    endcase
  end

  always_ff @(posedge global_bus) begin
    if (rst || flush) begin
      alu_wb_valid <= 1'b0;
    end else begin
      alu_wb_valid <= alu_valid;
    end
  end

  always_ff @(posedge global_bus) begin
    alu_wb_tag   <= disp_tag;
    alu_wb_value <= result;
    alu_wb_taken <= taken;
  end

endmodule

// File: logic/mul_unit.sv
module mul_unit (
  input  logic            global_bus,
  input  logic            rst,
  input  logic            flush,
  input  logic            mul_valid,
  input  rob_pkg::word_t  disp_a,
  input  rob_pkg::word_t  disp_b,
  input  rob_pkg::tag_t   disp_tag,
  output logic            mul_wb_valid,
  output rob_pkg::tag_t   mul_wb_tag,
  output rob_pkg::word_t  mul_wb_value
);

  logic [rob_pkg::mul_latency-1:0] valid_q;
  rob_pkg::tag_t                   tag_q [rob_pkg::mul_latency];

  // stage 1 holds the two byte-wide partial products.
  rob_pkg::word_t pp_lo_q;
  logic [7:0]     pp_hi_q;
  // stage 2 holds the summed product, stage 3 the result.
  rob_pkg::word_t sum_q;
  rob_pkg::word_t prod_q;

  always_ff @(posedge global_bus) begin
    if (rst || flush) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[rob_pkg::mul_latency-2:0], mul_valid};
    end
  end

  always_ff @(posedge global_bus) begin
    tag_q[0] <= disp_tag;
    for (int i = 1; i < rob_pkg::mul_latency; i++) begin
      tag_q[i] <= tag_q[i-1];
    end
  end

  // only the low 16 bits of the product are kept, so the upper partial needs 8.
  always_ff @(posedge global_bus) begin
    pp_lo_q <= disp_a * disp_b[7:0];
    pp_hi_q <= disp_a[7:0] * disp_b[15:8];
    sum_q   <= pp_lo_q + {pp_hi_q, 8'h00};
    prod_q  <= sum_q;
  end

  assign mul_wb_valid = valid_q[rob_pkg::mul_latency-1];
  assign mul_wb_tag   = tag_q[rob_pkg::mul_latency-1];
  assign mul_wb_value = prod_q;

endmodule

// File: logic/reorder_buffer.sv
module reorder_buffer (
  input  logic            global_bus,
  input  logic            rst,
  input  logic            flush,
  input  logic            alloc_valid,
  input  rob_pkg::pc_t    alloc_pc,
  input  rob_pkg::reg_t   alloc_rd,
  input  rob_pkg::pc_t    disp_target,
  output rob_pkg::tag_t   alloc_tag,
  input  logic            alu_wb_valid,
  input  rob_pkg::tag_t   alu_wb_tag,
  input  rob_pkg::word_t  alu_wb_value,
  input  logic            alu_wb_taken,
  input  logic            mul_wb_valid,
  input  rob_pkg::tag_t   mul_wb_tag,
  input  rob_pkg::word_t  mul_wb_value,
  output logic            full,
  output logic            retire_valid,
  output rob_pkg::pc_t    retire_pc,
  output rob_pkg::reg_t   retire_rd,
  output rob_pkg::word_t  retire_value,
  output logic            retire_taken,
  output rob_pkg::pc_t    retire_target
);

  rob_pkg::entry_state_e state  [rob_pkg::rob_depth];
  rob_pkg::pc_t          pc     [rob_pkg::rob_depth];
  rob_pkg::reg_t         rd     [rob_pkg::rob_depth];
  rob_pkg::word_t        value  [rob_pkg::rob_depth];
  logic                  taken  [rob_pkg::rob_depth];
  rob_pkg::pc_t          target [rob_pkg::rob_depth];

  rob_pkg::tag_t   head;
  rob_pkg::tag_t   tail;
  rob_pkg::count_t count;

  assign alloc_tag = tail;

  // the head leaves as soon as its result is in.
  assign retire_valid  = (state[head] == rob_pkg::st_done) && !flush;
  assign retire_pc     = pc[head];
  assign retire_rd     = rd[head];
  assign retire_value  = value[head];
  assign retire_taken  = taken[head];
  assign retire_target = target[head];

  // keep room for the instructions still between the input port and allocation.
  assign full = (count > rob_pkg::count_t'(rob_pkg::rob_depth - rob_pkg::full_margin));

  always_ff @(posedge global_bus) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < rob_pkg::rob_depth; i++) begin
        state[i] <= rob_pkg::st_free;
      end
    end else begin
      if (alloc_valid) begin
        state[tail] <= rob_pkg::st_waiting;
        tail        <= tail + 1'b1;
      end
      // both units may write back in one cycle, always to different tags.
      if (alu_wb_valid) begin
        state[alu_wb_tag] <= rob_pkg::st_done;
      end
      if (mul_wb_valid) begin
        state[mul_wb_tag] <= rob_pkg::st_done;
      end
      if (retire_valid) begin
        state[head] <= rob_pkg::st_free;
        head        <= head + 1'b1;
      end
      if (alloc_valid && !retire_valid) begin
        count <= count + 1'b1;
      end else if (!alloc_valid && retire_valid) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge global_bus) begin
    if (alloc_valid) begin
      pc[tail]     <= alloc_pc;
      rd[tail]     <= alloc_rd;
      target[tail] <= disp_target;
    end
    if (alu_wb_valid) begin
      value[alu_wb_tag] <= alu_wb_value;
      taken[alu_wb_tag] <= alu_wb_taken;
    end
    if (mul_wb_valid) begin
      value[mul_wb_tag] <= mul_wb_value;
      taken[mul_wb_tag] <= 1'b0;
    end
  end

endmodule

// File: logic/commit_stage.sv
module commit_stage (
  input  logic            global_bus,
  input  logic            rst,
  input  logic            retire_valid,
  input  rob_pkg::pc_t    retire_pc,
  input  rob_pkg::reg_t   retire_rd,
  input  rob_pkg::word_t  retire_value,
  input  logic            retire_taken,
  input  rob_pkg::pc_t    retire_target,
  output logic            commit_valid,
  output rob_pkg::pc_t    commit_pc,
  output rob_pkg::reg_t   commit_rd,
  output rob_pkg::word_t  commit_value,
  output logic            redirect_valid,
  output rob_pkg::pc_t    redirect_pc,
  output logic            flush
);

  // a taken branch was predicted not-taken, so it always redirects.
  logic mispredict;

  assign mispredict = retire_valid && retire_taken;

  always_ff @(posedge global_bus) begin
    if (rst) begin
      commit_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      commit_valid   <= retire_valid;
      redirect_valid <= mispredict;
    end
  end

  // branches already carry rd 0 and value 0 from issue and the alu.
  always_ff @(posedge global_bus) begin
    commit_pc    <= retire_pc;
    commit_rd    <= retire_rd;
    commit_value <= retire_value;
    redirect_pc  <= retire_target;
  end

  // the buffer shows no retire while this is high, so a redirect lasts one cycle.
  assign flush = redirect_valid;

endmodule

// File: logic/ooo_core_top.sv
module ooo_core_top (
  input  logic            global_bus,
  input  logic            rst,
  input  logic            in_valid,
  input  rob_pkg::op_e    in_op,
  input  rob_pkg::pc_t    in_pc,
  input  rob_pkg::reg_t   in_rd,
  input  rob_pkg::word_t  in_a,
  input  rob_pkg::word_t  in_b,
  input  rob_pkg::pc_t    in_target,
  output logic            full,
  output logic            commit_valid,
  output rob_pkg::pc_t    commit_pc,
  output rob_pkg::reg_t   commit_rd,
  output rob_pkg::word_t  commit_value,
  output logic            redirect_valid,
  output rob_pkg::pc_t    redirect_pc
);

  logic           flush;
  logic           alloc_valid;
  rob_pkg::pc_t   alloc_pc;
  rob_pkg::reg_t  alloc_rd;
  rob_pkg::tag_t  alloc_tag;
  logic           alu_valid;
  logic           mul_valid;
  rob_pkg::op_e   disp_op;
  rob_pkg::word_t disp_a;
  rob_pkg::word_t disp_b;
  rob_pkg::pc_t   disp_target;
  rob_pkg::tag_t  disp_tag;
  logic           alu_wb_valid;
  rob_pkg::tag_t  alu_wb_tag;
  rob_pkg::word_t alu_wb_value;
  logic           alu_wb_taken;
  logic           mul_wb_valid;
  rob_pkg::tag_t  mul_wb_tag;
  rob_pkg::word_t mul_wb_value;
  logic           retire_valid;
  rob_pkg::pc_t   retire_pc;
  rob_pkg::reg_t  retire_rd;
  rob_pkg::word_t retire_value;
  logic           retire_taken;
  rob_pkg::pc_t   retire_target;

  issue_stage issue_stage_i (
    .global_bus  (global_bus),
    .rst         (rst),
    .flush       (flush),
    .in_valid    (in_valid),
    .in_op       (in_op),
    .in_pc       (in_pc),
    .in_rd       (in_rd),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_target   (in_target),
    .alloc_tag   (alloc_tag),
    .alloc_valid (alloc_valid),
    .alloc_pc    (alloc_pc),
    .alloc_rd    (alloc_rd),
    .alu_valid   (alu_valid),
    .mul_valid   (mul_valid),
    .disp_op     (disp_op),
    .disp_a      (disp_a),
    .disp_b      (disp_b),
    .disp_target (disp_target),
    .disp_tag    (disp_tag)
  );

  alu_unit alu_unit_i (
    .global_bus   (global_bus),
    .rst          (rst),
    .flush        (flush),
    .alu_valid    (alu_valid),
    .disp_op      (disp_op),
    .disp_a       (disp_a),
    .disp_b       (disp_b),
    .disp_tag     (disp_tag),
    .alu_wb_valid (alu_wb_valid),
    .alu_wb_tag   (alu_wb_tag),
    .alu_wb_value (alu_wb_value),
    .alu_wb_taken (alu_wb_taken)
  );

  mul_unit mul_unit_i (
    .global_bus   (global_bus),
    .rst          (rst),
    .flush        (flush),
    .mul_valid    (mul_valid),
    .disp_a       (disp_a),
    .disp_b       (disp_b),
    .disp_tag     (disp_tag),
    .mul_wb_valid (mul_wb_valid),
    .mul_wb_tag   (mul_wb_tag),
    .mul_wb_value (mul_wb_value)
  );

  reorder_buffer reorder_buffer_i (
    .global_bus    (global_bus),
    .rst           (rst),
    .flush         (flush),
    .alloc_valid   (alloc_valid),
    .alloc_pc      (alloc_pc),
    .alloc_rd      (alloc_rd),
    .disp_target   (disp_target),
    .alloc_tag     (alloc_tag),
    .alu_wb_valid  (alu_wb_valid),
    .alu_wb_tag    (alu_wb_tag),
    .alu_wb_value  (alu_wb_value),
    .alu_wb_taken  (alu_wb_taken),
    .mul_wb_valid  (mul_wb_valid),
    .mul_wb_tag    (mul_wb_tag),
    .mul_wb_value  (mul_wb_value),
    .full          (full),
    .retire_valid  (retire_valid),
    .retire_pc     (retire_pc),
    .retire_rd     (retire_rd),
    .retire_value  (retire_value),
    .retire_taken  (retire_taken),
    .retire_target (retire_target)
  );

  commit_stage commit_stage_i (
    .global_bus     (global_bus),
    .rst            (rst),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_value   (retire_value),
    .retire_taken   (retire_taken),
    .retire_target  (retire_target),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd      (commit_rd),
    .commit_value   (commit_value),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .flush          (flush)
  );

endmodule

// File: test/ooo_core_tb.sv
module ooo_core_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int prog_len = 28;
  localparam int clk_period = 20;
  localparam int watchdog_ns = prog_len * (rob_pkg::mul_latency + 8) * clk_period * 4;

  logic           global_bus;
  logic           rst;
  logic           in_valid;
  rob_pkg::op_e   in_op;
  rob_pkg::pc_t   in_pc;
  rob_pkg::reg_t  in_rd;
  rob_pkg::word_t in_a;
  rob_pkg::word_t in_b;
  rob_pkg::pc_t   in_target;
  logic           full;
  logic           commit_valid;
  rob_pkg::pc_t   commit_pc;
  rob_pkg::reg_t  commit_rd;
  rob_pkg::word_t commit_value;
  logic           redirect_valid;
  rob_pkg::pc_t   redirect_pc;

  // program table, indexed by pc.
  rob_pkg::op_e   prog_op     [prog_len];
  rob_pkg::reg_t  prog_rd     [prog_len];
  rob_pkg::word_t prog_a      [prog_len];
  rob_pkg::word_t prog_b      [prog_len];
  rob_pkg::pc_t   prog_target [prog_len];
  bit             prog_dense  [prog_len];

  // expected commit sequence in program order.
  rob_pkg::pc_t   exp_pc       [prog_len];
  rob_pkg::reg_t  exp_rd       [prog_len];
  rob_pkg::word_t exp_value    [prog_len];
  bit             exp_redirect [prog_len];
  rob_pkg::pc_t   exp_target   [prog_len];
  int             exp_total;
  int             exp_idx;
  int             errors;

  ooo_core_top ooo_core_top_i (
    .global_bus     (global_bus),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_op          (in_op),
    .in_pc          (in_pc),
    .in_rd          (in_rd),
    .in_a           (in_a),
    .in_b           (in_b),
    .in_target      (in_target),
    .full           (full),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .commit_rd      (commit_rd),
    .commit_value   (commit_value),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    global_bus = 1'b0;
    forever #(clk_period / 2) global_bus = ~global_bus;
  end

  task automatic set_row(input int pc, input rob_pkg::op_e op, input rob_pkg::reg_t rd,
                         input rob_pkg::word_t a, input rob_pkg::word_t b,
                         input rob_pkg::pc_t target, input bit dense);
    prog_op[pc]     = op;
    prog_rd[pc]     = rd;
    prog_a[pc]      = a;
    prog_b[pc]      = b;
    prog_target[pc] = target;
    prog_dense[pc]  = dense;
  endtask

  task automatic load_program();
    set_row(0, rob_pkg::op_add, 3'd1, 16'h0005, 16'h0007, 8'h00, 1'b0);
    set_row(1, rob_pkg::op_sub, 3'd2, 16'h0014, 16'h0003, 8'h00, 1'b0);
    set_row(2, rob_pkg::op_mul, 3'd3, 16'h0006, 16'h0007, 8'h00, 1'b0);
    set_row(3, rob_pkg::op_add, 3'd4, 16'hffff, 16'h0002, 8'h00, 1'b0);
    set_row(4, rob_pkg::op_sub, 3'd5, 16'h0003, 16'h0005, 8'h00, 1'b0);
    set_row(5, rob_pkg::op_mul, 3'd6, 16'h1234, 16'h0056, 8'h00, 1'b0);
    // multiply overtaken by the two adds behind it.
    set_row(6, rob_pkg::op_mul, 3'd1, 16'h0123, 16'h0456, 8'h00, 1'b1);
    set_row(7, rob_pkg::op_add, 3'd2, 16'h1000, 16'h0234, 8'h00, 1'b1);
    set_row(8, rob_pkg::op_add, 3'd3, 16'h00aa, 16'h0055, 8'h00, 1'b1);
    set_row(9, rob_pkg::op_beq, 3'd5, 16'h0001, 16'h0002, 8'd20, 1'b0);
    set_row(10, rob_pkg::op_add, 3'd4, 16'h0100, 16'h0001, 8'h00, 1'b0);
    set_row(11, rob_pkg::op_beq, 3'd6, 16'h0009, 16'h0009, 8'd14, 1'b0);
    set_row(12, rob_pkg::op_add, 3'd5, 16'hdead, 16'h0001, 8'h00, 1'b0);
    set_row(13, rob_pkg::op_mul, 3'd6, 16'hbeef, 16'h0002, 8'h00, 1'b0);
    set_row(14, rob_pkg::op_add, 3'd7, 16'h0040, 16'h0002, 8'h00, 1'b0);
    // back to back multiplies.
    for (int i = 15; i < 23; i++) begin
      set_row(i, rob_pkg::op_mul, rob_pkg::reg_t'(i), rob_pkg::word_t'(i * 257),
              rob_pkg::word_t'(i + 3), 8'h00, 1'b1);
    end
    set_row(23, rob_pkg::op_beq, 3'd1, 16'h0000, 16'h0000, 8'd26, 1'b0);
    set_row(24, rob_pkg::op_sub, 3'd2, 16'h7777, 16'h1111, 8'h00, 1'b0);
    set_row(25, rob_pkg::op_add, 3'd3, 16'h5555, 16'h1111, 8'h00, 1'b0);
    set_row(26, rob_pkg::op_add, 3'd1, 16'h8000, 16'h8000, 8'h00, 1'b0);
    set_row(27, rob_pkg::op_mul, 3'd2, 16'hffff, 16'hffff, 8'h00, 1'b0);
  endtask

  function automatic rob_pkg::word_t reference_value(input rob_pkg::op_e op,
                                                     input rob_pkg::word_t a,
                                                     input rob_pkg::word_t b);
    logic [31:0] product;
    product = {16'h0000, a} * {16'h0000, b};
    case (op)
      rob_pkg::op_add: return a + b;
      rob_pkg::op_sub: return a - b;
      rob_pkg::op_mul: return product[15:0];
      default:         return '0;
    endcase
  endfunction

  initial begin : main
    int pc;
    rst = 1'b1;
    errors = 0;
    exp_idx = 0;
    exp_total = 0;
    load_program();
    // reference walk: fall through, or jump on a taken branch.
    pc = 0;
    while (pc < prog_len) begin
      exp_pc[exp_total]       = rob_pkg::pc_t'(pc);
      exp_rd[exp_total]       = (prog_op[pc] == rob_pkg::op_beq) ? '0 : prog_rd[pc];
      exp_value[exp_total]    = reference_value(prog_op[pc], prog_a[pc], prog_b[pc]);
      exp_redirect[exp_total] = (prog_op[pc] == rob_pkg::op_beq) && (prog_a[pc] == prog_b[pc]);
      exp_target[exp_total]   = prog_target[pc];
      exp_total++;
      if (exp_redirect[exp_total-1]) begin
        pc = prog_target[pc];
      end else begin
        pc++;
      end
    end
    repeat (2) @(posedge global_bus);
    rst <= 1'b0;
    @(negedge global_bus);
    if (commit_valid !== 1'b0) begin
      errors++;
      $display("[ERROR] commit_valid after reset: got 0x%h, expected 0x0", commit_valid);
    end
    if (redirect_valid !== 1'b0) begin
      errors++;
      $display("[ERROR] redirect_valid after reset: got 0x%h, expected 0x0", redirect_valid);
    end
    if (full !== 1'b0) begin
      errors++;
      $display("[ERROR] full after reset: got 0x%h, expected 0x0", full);
    end
    wait (exp_idx == exp_total);
    // idle a while so that a stray late commit still shows up.
    repeat (12) @(posedge global_bus);
    $display("errors: %0d, commits checked: %0d of %0d", errors, exp_idx, exp_total);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : stimulus
    int unsigned draw;
    int          pc;
    draw = $urandom(90262);
    pc = 0;
    in_valid  = 1'b0;
    in_op     = rob_pkg::op_add;
    in_pc     = '0;
    in_rd     = '0;
    in_a      = '0;
    in_b      = '0;
    in_target = '0;
    forever begin
      @(posedge global_bus);
      draw = $urandom;
      if (rst) begin
        in_valid <= 1'b0;
      end else if (redirect_valid) begin
        pc = redirect_pc;
        in_valid <= 1'b0;
      end else if (!full && pc < prog_len && (prog_dense[pc] || draw % 4 != 0)) begin
        in_valid  <= 1'b1;
        in_op     <= prog_op[pc];
        in_pc     <= rob_pkg::pc_t'(pc);
        in_rd     <= prog_rd[pc];
        in_a      <= prog_a[pc];
        in_b      <= prog_b[pc];
        in_target <= prog_target[pc];
        pc++;
      end else begin
        in_valid <= 1'b0;
      end
    end
  end

  // outputs are registered, so the falling edge sees them settled.
  always @(negedge global_bus) begin
    if (!rst && commit_valid) begin
      if (exp_idx >= exp_total) begin
        errors++;
        $display("unexpected commit of pc 0x%h after the whole program committed", commit_pc);
      end else begin
        if (commit_pc !== exp_pc[exp_idx]) begin
          errors++;
          $display("[ERROR] commit_pc: got 0x%h, expected 0x%h", commit_pc, exp_pc[exp_idx]);
        end
        if (commit_rd !== exp_rd[exp_idx]) begin
          errors++;
          $display("[ERROR] commit_rd at pc 0x%h: got 0x%h, expected 0x%h",
                   exp_pc[exp_idx], commit_rd, exp_rd[exp_idx]);
        end
        if (commit_value !== exp_value[exp_idx]) begin
          errors++;
          $display("[ERROR] commit_value at pc 0x%h: got 0x%h, expected 0x%h",
                   exp_pc[exp_idx], commit_value, exp_value[exp_idx]);
        end
        if (redirect_valid !== exp_redirect[exp_idx]) begin
          errors++;
          $display("[ERROR] redirect_valid at pc 0x%h: got 0x%h, expected 0x%h",
                   exp_pc[exp_idx], redirect_valid, exp_redirect[exp_idx]);
        end else if (exp_redirect[exp_idx] && redirect_pc !== exp_target[exp_idx]) begin
          errors++;
          $display("[ERROR] redirect_pc: got 0x%h, expected 0x%h",
                   redirect_pc, exp_target[exp_idx]);
        end
        exp_idx++;
      end
    end else if (!rst && redirect_valid) begin
      errors++;
      $display("redirect to 0x%h raised without a committing branch", redirect_pc);
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout after %0d ns, commits still missing", watchdog_ns);
    $display("errors: %0d, commits checked: %0d of %0d", errors + 1, exp_idx, exp_total);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog.f
logic/rob_pkg.sv
logic/issue_stage.sv
logic/alu_unit.sv
logic/mul_unit.sv
logic/reorder_buffer.sv
logic/commit_stage.sv
logic/ooo_core_top.sv
test/ooo_core_tb.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - logic/rob_pkg.sv
  - logic/issue_stage.sv
  - logic/alu_unit.sv
  - logic/mul_unit.sv
  - logic/reorder_buffer.sv
  - logic/commit_stage.sv
  - logic/ooo_core_top.sv
  - target: test
    files:
      - test/ooo_core_tb.sv
